//--- design/memPkg.sv
// bus opcodes, answer codes, arbiter states and exception codes shared by the L1 blocks and the testbench
package memPkg;

	// operation on the external memory bus
	typedef enum logic [1:0]
	{
		opmReady = 2'd0,	// bus idle
		opmLoad = 2'd1,		// single word read
		opmStore = 2'd2		// single word write
	} memOpm;

	// answer code on the bus and toward the core
	typedef enum logic [1:0]
	{
		okReady = 2'd0,		// nothing pending
		okHold = 2'd1,		// still waiting
		okDone = 2'd2,		// finished, data valid
		okFault = 2'd3		// finished with an error
	} memOk;

	// who owns the bus
	typedef enum logic [1:0]
	{
		stIdle = 2'd0,
		stIcFill = 2'd1,	// instruction line refill
		stDcFill = 2'd2,	// data line refill
		stDcStore = 2'd3	// write-through store
	} arbState;

	// exception codes sent out together with the faulting address
	localparam logic [15:0] excBusFault = 16'h8000;	// bus answered okFault
	localparam logic [15:0] excAlign1 = 16'h8001;	// address bit 0 set
	localparam logic [15:0] excAlign2 = 16'h8002;	// only address bit 1 set
	localparam logic [15:0] excTimeout = 16'h8004;	// watchdog ran out

	// words per cache line
	// a line is 16 bytes so the offset is addr[3:0] and the word select is addr[3:2]
	localparam logic [31:0] lineWords = 32'd4;

endpackage

//--- design/busBeatTimer.sv
// counts refill beats and watches how long the current bus beat has waited for an answer
module busBeatTimer #(
	parameter int waitLimit = 64	// cycles without answer before giving up
)
(
	input logic clock,
	input logic rstN,
	input logic beatStart,
	input logic beatAdvance,
	input memPkg::memOk memOk,
	output logic [1:0] beatIndex,
	output logic lastBeat,
	output logic waitExpired
);
	import memPkg::*;

	localparam int cntBits = $clog2(waitLimit + 1);

	logic [cntBits-1:0] waitCount;	// saturates at the limit
	logic answered;

	assign answered = (memOk == okDone) || (memOk == okFault);
	assign lastBeat = {30'd0, beatIndex} == (lineWords - 32'd1);
	assign waitExpired = waitCount == cntBits'(waitLimit);

	always_ff @(posedge clock)
	begin
		if (!rstN || beatStart)
		begin
			beatIndex <= 2'd0;
			waitCount <= '0;
		end
		else
		begin
			if (beatAdvance)
				beatIndex <= beatIndex + 2'd1;
			if (answered || beatAdvance)
				waitCount <= '0;	// fresh beat
			else if (!waitExpired)
				waitCount <= waitCount + 1'b1;
		end
	end

endmodule

//--- design/instCache.sv
// direct-mapped read-only instruction cache; hits answer the next cycle, misses refill a line over the bus
module instCache #(
	parameter int lineCount = 16	// power of two, at least 2
)
(
	input logic clock,
	input logic rstN,
	input logic icReq,
	input logic [31:0] icAddr,
	output logic [31:0] icData,
	output memPkg::memOk icOk,
	output logic fillReq,
	output logic [31:0] fillAddr,
	input logic [31:0] fillWord,
	input logic fillBeat,
	input logic [1:0] fillIndex,
	input logic fillDone,
	input logic fillFault
);
	import memPkg::*;

	localparam int idxBits = $clog2(lineCount);
	localparam int tagBits = 28 - idxBits;	// above line offset and index

	logic [tagBits-1:0] tagMem [lineCount];
	logic [31:0] dataMem [lineCount][lineWords];
	logic [lineCount-1:0] validMem;

	logic pending;				// refill in progress, no new requests
	logic [31:0] missAddr;		// address of the request that missed
	logic [31:0] fillCatch;		// requested word, grabbed as it flies past

	logic [idxBits-1:0] reqIdx;
	logic [tagBits-1:0] reqTag;
	logic [1:0] reqWord;
	logic reqHit;
	logic [idxBits-1:0] missIdx;

	assign reqIdx = icAddr[4 +: idxBits];
	assign reqTag = icAddr[31 -: tagBits];
	assign reqWord = icAddr[3:2];
	assign reqHit = validMem[reqIdx] && (tagMem[reqIdx] == reqTag);
	assign missIdx = missAddr[4 +: idxBits];

	assign fillReq = pending;
	assign fillAddr = {missAddr[31:4], 4'b0000};	// line aligned, arbiter adds beat

	// control state and answer strobe
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			validMem <= '0;
			pending <= 1'b0;
			icOk <= okReady;
		end
		else
		begin
			icOk <= okReady;	// one-cycle strobe
			if (pending)
			begin
				if (fillFault)
				begin
					pending <= 1'b0;
					icOk <= okFault;	// line stays invalid
				end
				else if (fillDone)
				begin
					pending <= 1'b0;
					validMem[missIdx] <= 1'b1;
					icOk <= okDone;
				end
			end
			else if (icReq)
			begin
				if (reqHit)
					icOk <= okDone;
				else
				begin
					pending <= 1'b1;
					validMem[reqIdx] <= 1'b0;	// old line gets overwritten by the refill
				end
			end
		end
	end

	// arrays and read data
	always_ff @(posedge clock)
	begin
		if (icReq && !pending)
		begin
			icData <= dataMem[reqIdx][reqWord];
			missAddr <= icAddr;
		end
		if (pending && fillBeat)
		begin
			dataMem[missIdx][fillIndex] <= fillWord;
			if (fillIndex == missAddr[3:2])
				fillCatch <= fillWord;
		end
		// fillDone comes with the last beat, so that beat may be the wanted word
		if (pending && fillDone)
		begin
			tagMem[missIdx] <= missAddr[31 -: tagBits];
			icData <= (fillIndex == missAddr[3:2]) ? fillWord : fillCatch;
		end
	end

endmodule

//--- design/dataCache.sv
// direct-mapped write-through data cache; loads refill lines, stores go to the bus, no write-allocate
module dataCache #(
	parameter int lineCount = 16	// power of two, at least 2
)
(
	input logic clock,
	input logic rstN,
	input logic dcReq,
	input logic [31:0] dcAddr,
	input logic dcWrite,
	input logic [31:0] dcWData,
	output logic [31:0] dcRData,
	output memPkg::memOk dcOk,
	output logic fillReq,
	output logic [31:0] fillAddr,
	input logic [31:0] fillWord,
	input logic fillBeat,
	input logic [1:0] fillIndex,
	input logic fillDone,
	input logic fillFault,		// bus fault or timeout, refill or store
	output logic storeReq,
	output logic [31:0] storeAddr,
	output logic [31:0] storeData,
	input logic storeDone,
	output logic alignFault,
	output logic [31:0] alignAddr
);
	import memPkg::*;

	localparam int idxBits = $clog2(lineCount);
	localparam int tagBits = 28 - idxBits;

	logic [tagBits-1:0] tagMem [lineCount];
	logic [31:0] dataMem [lineCount][lineWords];
	logic [lineCount-1:0] validMem;

	logic loadPending;			// line refill outstanding
	logic storePending;			// bus write outstanding
	logic [31:0] reqAddr;		// last accepted address
	logic [31:0] fillCatch;

	logic accept;
	logic misaligned;
	logic [idxBits-1:0] reqIdx;
	logic [tagBits-1:0] reqTag;
	logic [1:0] reqWord;
	logic reqHit;
	logic [idxBits-1:0] missIdx;

	assign accept = dcReq && !loadPending && !storePending;
	assign misaligned = dcAddr[1:0] != 2'b00;
	assign reqIdx = dcAddr[4 +: idxBits];
	assign reqTag = dcAddr[31 -: tagBits];
	assign reqWord = dcAddr[3:2];
	assign reqHit = validMem[reqIdx] && (tagMem[reqIdx] == reqTag);
	assign missIdx = reqAddr[4 +: idxBits];

	assign fillReq = loadPending;
	assign fillAddr = {reqAddr[31:4], 4'b0000};
	assign storeReq = storePending;
	assign storeAddr = reqAddr;

	// misaligned access never reaches the bus, arbiter registers the exception
	assign alignFault = accept && misaligned;
	assign alignAddr = dcAddr;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			validMem <= '0;
			loadPending <= 1'b0;
			storePending <= 1'b0;
			dcOk <= okReady;
		end
		else
		begin
			dcOk <= okReady;	// strobe
			if (loadPending)
			begin
				if (fillFault)
				begin
					loadPending <= 1'b0;
					dcOk <= okFault;
				end
				else if (fillDone)
				begin
					loadPending <= 1'b0;
					validMem[missIdx] <= 1'b1;
					dcOk <= okDone;
				end
			end
			else if (storePending)
			begin
				if (fillFault)
				begin
					storePending <= 1'b0;
					dcOk <= okFault;
				end
				else if (storeDone)
				begin
					storePending <= 1'b0;
					dcOk <= okDone;
				end
			end
			else if (dcReq)
			begin
				if (misaligned)
					dcOk <= okFault;	// next cycle, no bus
				else if (dcWrite)
					storePending <= 1'b1;	// every store goes through
				else if (reqHit)
					dcOk <= okDone;
				else
				begin
					loadPending <= 1'b1;
					validMem[reqIdx] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			dcRData <= dataMem[reqIdx][reqWord];
			reqAddr <= dcAddr;
			storeData <= dcWData;
			if (dcWrite && reqHit && !misaligned)
				dataMem[reqIdx][reqWord] <= dcWData;	// keep cached copy current
		end
		if (loadPending && fillBeat)
		begin
			dataMem[missIdx][fillIndex] <= fillWord;
			if (fillIndex == reqAddr[3:2])
				fillCatch <= fillWord;
		end
		if (loadPending && fillDone)
		begin
			tagMem[missIdx] <= reqAddr[31 -: tagBits];
			dcRData <= (fillIndex == reqAddr[3:2]) ? fillWord : fillCatch;
		end
	end

endmodule

//--- design/busArbiter.sv
// grants the shared memory bus to one cache at a time, holds the grant until done, registers exceptions
module busArbiter
(
	input logic clock,
	input logic rstN,
	output memPkg::memOpm memOpm,
	output logic [31:0] memAddr,
	output logic [31:0] memWData,
	input memPkg::memOk memOk,
	input logic icFillReq,
	input logic [31:0] icFillAddr,
	output logic icFillBeat,
	output logic icFillDone,
	output logic icFillFault,
	input logic dcFillReq,
	input logic [31:0] dcFillAddr,
	output logic dcFillBeat,
	output logic dcFillDone,
	output logic dcFillFault,
	input logic dcStoreReq,
	input logic [31:0] dcStoreAddr,
	input logic [31:0] dcStoreData,
	output logic dcStoreDone,
	input logic alignFault,
	input logic [31:0] alignAddr,
	output logic beatStart,
	output logic beatAdvance,
	input logic [1:0] beatIndex,
	input logic lastBeat,
	input logic waitExpired,
	output logic excValid,
	output logic [31:0] excAddr,
	output logic [15:0] excCode
);
	import memPkg::*;

	arbState state;			// the latched grant
	arbState stateNext;
	logic busy;
	logic beatDone;			// current beat answered okDone
	logic busFault;			// current beat answered okFault
	logic beatFault;		// fault or watchdog, ends the transaction
	logic [31:0] fillAddr;

	assign busy = state != stIdle;
	assign beatDone = busy && (memOk == okDone);
	assign busFault = busy && (memOk == okFault);
	assign beatFault = busFault || (busy && !beatDone && waitExpired);

	// bus follows the grant, beat address steps with the timer
	always_comb
	begin
		memOpm = opmReady;
		memAddr = 32'd0;
		memWData = 32'd0;
		fillAddr = (state == stIcFill) ? icFillAddr : dcFillAddr;
		case (state)
			stIcFill, stDcFill:
			begin
				memOpm = opmLoad;
				memAddr = {fillAddr[31:4], beatIndex, 2'b00};
			end
			stDcStore:
			begin
				memOpm = opmStore;
				memAddr = dcStoreAddr;
				memWData = dcStoreData;
			end
			default:
				memOpm = opmReady;
		endcase
	end

	// answers go only to the owner
	assign icFillBeat = (state == stIcFill) && beatDone;
	assign icFillDone = icFillBeat && lastBeat;
	assign icFillFault = (state == stIcFill) && beatFault;
	assign dcFillBeat = (state == stDcFill) && beatDone;
	assign dcFillDone = dcFillBeat && lastBeat;
	assign dcFillFault = ((state == stDcFill) || (state == stDcStore)) && beatFault;
	assign dcStoreDone = (state == stDcStore) && beatDone;

	assign beatStart = !busy && (icFillReq || dcFillReq || dcStoreReq);	// clears the timer
	assign beatAdvance = beatDone;

	always_comb
	begin
		stateNext = state;
		case (state)
			stIdle:
				if (icFillReq)
					stateNext = stIcFill;	// instruction side wins ties
				else if (dcFillReq)
					stateNext = stDcFill;
				else if (dcStoreReq)
					stateNext = stDcStore;
			stIcFill, stDcFill:
				if (beatFault || (beatDone && lastBeat))
					stateNext = stIdle;
			default:
				if (beatFault || beatDone)	// store is a single beat
					stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			excValid <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			excValid <= beatFault || alignFault;
		end
	end

	// bus side faults win over a same-cycle align fault
	always_ff @(posedge clock)
	begin
		if (beatFault)
		begin
			excAddr <= memAddr;
			excCode <= busFault ? excBusFault : excTimeout;
		end
		else if (alignFault)
		begin
			excAddr <= alignAddr;
			excCode <= alignAddr[0] ? excAlign1 : excAlign2;
		end
	end

endmodule

//--- design/memL1.sv
// L1 top level; joins instruction cache, data cache, bus arbiter and beat timer between core and bus
module memL1 #(
	parameter int lineCount = 16,
	parameter int waitLimit = 64
)
(
	input logic clock,
	input logic rstN,
	input logic icReq,
	input logic [31:0] icAddr,
	output logic [31:0] icData,
	output memPkg::memOk icOk,
	input logic dcReq,
	input logic [31:0] dcAddr,
	input logic dcWrite,
	input logic [31:0] dcWData,
	output logic [31:0] dcRData,
	output memPkg::memOk dcOk,
	output memPkg::memOpm memOpm,
	output logic [31:0] memAddr,
	output logic [31:0] memWData,
	input logic [31:0] memRData,
	input memPkg::memOk memOk,
	output logic excValid,
	output logic [31:0] excAddr,
	output logic [15:0] excCode
);
	// cache to arbiter
	logic icFillReq, icFillBeat, icFillDone, icFillFault;
	logic [31:0] icFillAddr;
	logic dcFillReq, dcFillBeat, dcFillDone, dcFillFault;
	logic [31:0] dcFillAddr;
	logic dcStoreReq, dcStoreDone;
	logic [31:0] dcStoreAddr, dcStoreData;
	logic alignFault;
	logic [31:0] alignAddr;
	// arbiter to timer
	logic beatStart, beatAdvance, lastBeat, waitExpired;
	logic [1:0] beatIndex;

	instCache #(.lineCount(lineCount)) uInstCache (
		.clock(clock), .rstN(rstN), .icReq(icReq), .icAddr(icAddr), .icData(icData),
		.icOk(icOk), .fillReq(icFillReq), .fillAddr(icFillAddr), .fillWord(memRData),
		.fillBeat(icFillBeat), .fillIndex(beatIndex), .fillDone(icFillDone),
		.fillFault(icFillFault));

	dataCache #(.lineCount(lineCount)) uDataCache (
		.clock(clock), .rstN(rstN), .dcReq(dcReq), .dcAddr(dcAddr), .dcWrite(dcWrite),
		.dcWData(dcWData), .dcRData(dcRData), .dcOk(dcOk), .fillReq(dcFillReq),
		.fillAddr(dcFillAddr), .fillWord(memRData), .fillBeat(dcFillBeat),
		.fillIndex(beatIndex), .fillDone(dcFillDone), .fillFault(dcFillFault),
		.storeReq(dcStoreReq), .storeAddr(dcStoreAddr), .storeData(dcStoreData),
		.storeDone(dcStoreDone), .alignFault(alignFault), .alignAddr(alignAddr));

	busArbiter uBusArbiter (
		.clock(clock), .rstN(rstN), .memOpm(memOpm), .memAddr(memAddr),
		.memWData(memWData), .memOk(memOk), .icFillReq(icFillReq), .icFillAddr(icFillAddr),
		.icFillBeat(icFillBeat), .icFillDone(icFillDone), .icFillFault(icFillFault),
		.dcFillReq(dcFillReq), .dcFillAddr(dcFillAddr), .dcFillBeat(dcFillBeat),
		.dcFillDone(dcFillDone), .dcFillFault(dcFillFault), .dcStoreReq(dcStoreReq),
		.dcStoreAddr(dcStoreAddr), .dcStoreData(dcStoreData), .dcStoreDone(dcStoreDone),
		.alignFault(alignFault), .alignAddr(alignAddr), .beatStart(beatStart),
		.beatAdvance(beatAdvance), .beatIndex(beatIndex), .lastBeat(lastBeat),
		.waitExpired(waitExpired), .excValid(excValid), .excAddr(excAddr),
		.excCode(excCode));

	busBeatTimer #(.waitLimit(waitLimit)) uBusBeatTimer (
		.clock(clock), .rstN(rstN), .beatStart(beatStart), .beatAdvance(beatAdvance),
		.memOk(memOk), .beatIndex(beatIndex), .lastBeat(lastBeat),
		.waitExpired(waitExpired));

endmodule

//--- verif/tbClock.sv
// free running testbench clock, period 4, shared by the testbench and the bus model
module tbClock
(
	output logic clock
);

	initial
	begin
		clock = 1'b0;	// starts low, first rising edge at 2
	end

	always #2 clock = ~clock;	// half period

endmodule

//--- verif/busModel.sv
// memory bus model for the L1 testbench; image from the stimulus file, random latency, fault and stall regions
module busModel
(
	input logic clock,
	input logic rstN,
	input memPkg::memOpm memOpm,
	input logic [31:0] memAddr,
	input logic [31:0] memWData,
	output logic [31:0] memRData,
	output memPkg::memOk memOk
);
	import memPkg::*;

	logic [31:0] stim [0:255];
	logic [31:0] mem [0:1023];	// word array, addr[11:2]
	logic [31:0] faultBase;
	logic [31:0] stallBase;
	int seed = 67142;
	logic started;				// current beat has drawn its delay
	logic [1:0] delay;
	logic inFault;
	logic inStall;

	// default contents, different for every address
	function automatic logic [31:0] patternWord(input logic [31:0] addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a0f0f;
	endfunction

	initial
	begin
		$readmemh("verif/l1_stimulus.txt", stim);
		faultBase = stim[0];
		stallBase = stim[1];
		for (int i = 0; i < 1024; i++)
			mem[i] = patternWord(i << 2);
		for (int i = 0; i < 32; i++)
			mem[i] = stim[8 + i];	// image covers 0x00..0x7c
	end

	assign inFault = (memAddr >= faultBase) && (memAddr < faultBase + 32'h100);
	assign inStall = (memAddr >= stallBase) && (memAddr < stallBase + 32'h100);

	always @(posedge clock)
	begin
		int randVal;
		if (!rstN)
		begin
			memOk <= okReady;
			memRData <= 32'd0;
			started <= 1'b0;
			delay <= 2'd0;
		end
		else if (memOk == okDone || memOk == okFault)
		begin
			memOk <= okReady;	// answer lasts one cycle
			started <= 1'b0;
		end
		else if (memOpm == opmReady)
		begin
			memOk <= okReady;
			started <= 1'b0;	// also after a watchdog abort
		end
		else if (!started)
		begin
			randVal = $random(seed);
			delay <= randVal[1:0];	// 0..3 extra hold cycles
			started <= 1'b1;
			memOk <= okHold;
		end
		else if (inStall || delay != 2'd0)
		begin
			memOk <= okHold;	// stall region never answers
			if (delay != 2'd0)
				delay <= delay - 2'd1;
		end
		else if (inFault)
			memOk <= okFault;
		else
		begin
			memOk <= okDone;
			if (memOpm == opmLoad)
				memRData <= mem[memAddr[11:2]];
			else
				mem[memAddr[11:2]] <= memWData;	// write-through lands here
		end
	end

endmodule

//--- verif/memL1_props.sv
// concurrent checks bound into the bus arbiter to watch the bus handshake and the latched grant
module memL1Props
(
	input logic clock,
	input logic rstN,
	input memPkg::arbState state,
	input memPkg::memOpm memOpm,
	input memPkg::memOk memOk,
	input logic [31:0] memAddr,
	input logic [1:0] beatIndex,
	input logic waitExpired
);
	import memPkg::*;

	// a bus answer always belongs to a granted beat
	answerOwned: assert property (@(posedge clock) disable iff (!rstN)
		(memOk == okDone || memOk == okFault) |-> state != stIdle)
		else $error("bus answer arrived with no transaction on the bus");

	// a line refill keeps its grant until the fourth beat
	fillHeld: assert property (@(posedge clock) disable iff (!rstN)
		((state == stIcFill || state == stDcFill) && memOk == okDone && beatIndex != 2'd3)
		|=> $stable(state))
		else $error("grant changed between the beats of a line refill");

	// beat address steady until answered
	addrHeld: assert property (@(posedge clock) disable iff (!rstN)
		(memOpm != opmReady && memOk == okHold && !waitExpired) |=> $stable(memAddr))
		else $error("bus address moved during a held beat");

endmodule

bind busArbiter memL1Props uProps
(
	.clock(clock),
	.rstN(rstN),
	.state(state),
	.memOpm(memOpm),
	.memOk(memOk),
	.memAddr(memAddr),
	.beatIndex(beatIndex),
	.waitExpired(waitExpired)
);

//--- verif/memL1Tb.sv
// testbench top that runs the request lines of the stimulus file against the L1 subsystem and checks every answer
module memL1Tb;
	import memPkg::*;

	localparam int answerTimeout = 300;	// well above the watchdog limit

	logic clock;
	logic rstN;
	logic icReq, dcReq, dcWrite;
	logic [31:0] icAddr, dcAddr, dcWData;
	logic [31:0] icData, dcRData;
	memOk icOk, dcOk;
	memOpm busOpm;
	logic [31:0] memAddr, memWData, memRData;
	memOk busOk;
	logic excValid;
	logic [31:0] excAddr;
	logic [15:0] excCode;

	logic [31:0] stim [0:255];
	logic [31:0] imageCopy [0:1023];	// expected memory contents
	logic [31:0] storeExpect;			// data the next bus write must carry
	logic [31:0] storeAddrExpect;		// and the address it must go to
	memOk icGot, dcGot;
	logic [31:0] icWord, dcWord;
	logic excSeen;
	logic [15:0] excCodeSeen;
	logic [31:0] excAddrSeen;

	tbClock uClock (.clock(clock));

	busModel uBusModel (.clock(clock), .rstN(rstN), .memOpm(busOpm), .memAddr(memAddr),
		.memWData(memWData), .memRData(memRData), .memOk(busOk));

	memL1 #(.lineCount(16), .waitLimit(64)) u_dut (
		.clock(clock), .rstN(rstN), .icReq(icReq), .icAddr(icAddr), .icData(icData),
		.icOk(icOk), .dcReq(dcReq), .dcAddr(dcAddr), .dcWrite(dcWrite), .dcWData(dcWData),
		.dcRData(dcRData), .dcOk(dcOk), .memOpm(busOpm), .memAddr(memAddr),
		.memWData(memWData), .memRData(memRData), .memOk(busOk), .excValid(excValid),
		.excAddr(excAddr), .excCode(excCode));

	function automatic logic [31:0] patternWord(input logic [31:0] addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a0f0f;	// same fill as the bus model
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			failRun($sformatf("Error: %s is %h, expected %h", name, got, exp));
	endtask

	task automatic checkOk(input string name, input memOk got, input memOk exp);
		if (got !== exp)
			failRun($sformatf("Error: %s is %h, expected %h", name, got, exp));
	endtask

	// code 0 means no exception may show
	task automatic checkExc(input logic [15:0] expCode, input logic [31:0] expAddr);
		if (expCode == 16'h0)
		begin
			if (excSeen)
				failRun($sformatf("Error: excValid is 1, expected 0 (excCode %h)", excCodeSeen));
		end
		else if (!excSeen)
			failRun("Error: excValid is 0, expected 1");
		else
		begin
			checkWord("excCode", {16'h0, excCodeSeen}, {16'h0, expCode});
			checkWord("excAddr", excAddrSeen, expAddr);
		end
	endtask

	// samples at falling edges until every wanted port has answered
	task automatic waitAnswer(input bit wantIc, input bit wantDc, input bit mustHit,
		input bit noBus);
		int cycles;
		bit icSeen;
		bit dcSeen;
		cycles = 0;
		icSeen = !wantIc;
		dcSeen = !wantDc;
		excSeen = 1'b0;
		while (!(icSeen && dcSeen))
		begin
			@(negedge clock);
			cycles++;
			icReq = 1'b0;	// strobes last one cycle
			dcReq = 1'b0;
			dcWrite = 1'b0;
			if (busOpm == opmStore && busOk == okDone)
			begin
				checkWord("memAddr", memAddr, storeAddrExpect);
				checkWord("memWData", memWData, storeExpect);
			end
			if (excValid)
			begin
				excSeen = 1'b1;
				excCodeSeen = excCode;
				excAddrSeen = excAddr;
			end
			if (!icSeen && icOk != okReady)
			begin
				icSeen = 1'b1;
				icGot = icOk;
				icWord = icData;
			end
			if (!dcSeen && dcOk != okReady)
			begin
				dcSeen = 1'b1;
				dcGot = dcOk;
				dcWord = dcRData;
			end
			if (!(icSeen && dcSeen) && mustHit)
				failRun("a hit did not answer one cycle after its request");
			if (!(icSeen && dcSeen) && cycles >= answerTimeout)
				failRun("timeout, the cache never answered the request");
		end
		// a refill started by mistake would hold the bus by the next falling edge
		if (noBus)
		begin
			@(negedge clock);
			if (busOpm != opmReady)
				failRun("a misaligned access started a bus transaction");
		end
	endtask

	task automatic runRequest(input int base);
		logic [31:0] port, addr, data;
		bit hit;
		memOk expOk;
		logic [15:0] expExc;
		logic [31:0] expAddr;
		port = stim[base];
		addr = stim[base + 1];
		data = stim[base + 2];
		hit = stim[base + 3][0];
		expOk = memOk'(stim[base + 4][1:0]);
		expExc = stim[base + 5][15:0];
		// align faults report the exact address and bus faults the beat address
		expAddr = (expExc == excAlign1 || expExc == excAlign2) ? addr : {addr[31:4], 4'h0};
		case (port)
			0:
			begin
				icAddr = addr;
				icReq = 1'b1;
				waitAnswer(1'b1, 1'b0, hit, 1'b0);
				checkOk("icOk", icGot, expOk);
				if (expOk == okDone)
					checkWord("icData", icWord, imageCopy[addr[11:2]]);
			end
			1, 2:
			begin
				dcAddr = addr;
				dcWrite = (port == 2);
				dcWData = data;
				storeExpect = data;
				storeAddrExpect = addr;
				dcReq = 1'b1;
				waitAnswer(1'b0, 1'b1, hit, expExc == excAlign1 || expExc == excAlign2);
				checkOk("dcOk", dcGot, expOk);
				if (port == 2 && expOk == okDone)
					imageCopy[addr[11:2]] = data;
				else if (expOk == okDone)
					checkWord("dcRData", dcWord, imageCopy[addr[11:2]]);
			end
			3:
			begin
				icAddr = addr;	// both miss in the same cycle
				dcAddr = data;
				dcWrite = 1'b0;
				icReq = 1'b1;
				dcReq = 1'b1;
				waitAnswer(1'b1, 1'b1, 1'b0, 1'b0);
				checkOk("icOk", icGot, okDone);
				checkWord("icData", icWord, imageCopy[addr[11:2]]);
				checkOk("dcOk", dcGot, okDone);
				checkWord("dcRData", dcWord, imageCopy[data[11:2]]);
			end
			default:
			begin
				dcAddr = addr;	// two hits on back-to-back cycles
				dcWrite = 1'b0;
				dcReq = 1'b1;
				@(negedge clock);
				excSeen = excValid;
				excCodeSeen = excCode;
				checkOk("dcOk", dcOk, okDone);
				checkWord("dcRData", dcRData, imageCopy[addr[11:2]]);
				dcAddr = addr + 32'd4;
				@(negedge clock);
				dcReq = 1'b0;
				if (excValid)
				begin
					excSeen = 1'b1;
					excCodeSeen = excCode;
				end
				checkOk("dcOk", dcOk, okDone);
				checkWord("dcRData", dcRData, imageCopy[dcAddr[11:2]]);
			end
		endcase
		checkExc(expExc, expAddr);
	endtask

	initial
	begin
		rstN = 1'b0;
		icReq = 1'b0;
		icAddr = 32'd0;
		dcReq = 1'b0;
		dcAddr = 32'd0;
		dcWrite = 1'b0;
		dcWData = 32'd0;
		storeExpect = 32'd0;
		storeAddrExpect = 32'd0;
		$readmemh("verif/l1_stimulus.txt", stim);
		for (int i = 0; i < 1024; i++)
			imageCopy[i] = patternWord(i << 2);
		for (int i = 0; i < 32; i++)
			imageCopy[i] = stim[8 + i];
		repeat (4) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		for (int r = 0; r < int'(stim[2]); r++)
			runRequest(64 + 6 * r);	// six words per request line
		$display("TEST OK");
		$finish;
	end

endmodule

//--- verif/l1_stimulus.txt
// header: fault region base, stall region base, request count
// image: 32 words at byte addresses 0x00..0x7c; requests: port addr data hit expOk expExc
@0
00000800 00000c00 00000010
@8
10000000 10000004 10000008 1000000c 10000010 10000014 10000018 1000001c
10000020 10000024 10000028 1000002c 10000030 10000034 10000038 1000003c
10000040 10000044 10000048 1000004c 10000050 10000054 10000058 1000005c
10000060 10000064 10000068 1000006c 10000070 10000074 10000078 1000007c
@40
00000000 00000000 00000000 00000000 00000002 00000000
00000000 00000004 00000000 00000001 00000002 00000000
00000000 0000000c 00000000 00000001 00000002 00000000
00000001 00000040 00000000 00000000 00000002 00000000
00000004 00000044 00000000 00000001 00000002 00000000
00000002 00000048 cafef00d 00000000 00000002 00000000
00000001 00000048 00000000 00000001 00000002 00000000
00000002 00000070 12345678 00000000 00000002 00000000
00000001 00000070 00000000 00000000 00000002 00000000
00000003 00000020 00000060 00000000 00000002 00000000
00000001 00000800 00000000 00000000 00000003 00008000
00000001 00000041 00000000 00000001 00000003 00008001
00000001 00000042 00000000 00000001 00000003 00008002
00000000 00000c00 00000000 00000000 00000003 00008004
00000000 00000010 00000000 00000000 00000002 00000000
00000001 00000004 00000000 00000000 00000002 00000000

//--- verilog.f
design/memPkg.sv
design/busBeatTimer.sv
design/instCache.sv
design/dataCache.sv
design/busArbiter.sv
design/memL1.sv
verif/tbClock.sv
verif/busModel.sv
verif/memL1_props.sv
verif/memL1Tb.sv

//--- run.sh
#!/bin/sh
# builds the L1 testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module memL1Tb \
	-o memL1Sim && ./obj_dir/memL1Sim || exit 1
